//--- files.f
+incdir+include
hdl/rvv_backend_pkg.sv
hdl/rvv_uq_push_if.sv
hdl/rvv_cmd_queue.sv
hdl/rvv_decode_unit.sv
hdl/rvv_backend_decode_ctrl.sv
hdl/rvv_uop_queue.sv
hdl/rvv_backend_decode.sv
verification/tb_rvv_backend_decode.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f files.f --top-module tb_rvv_backend_decode -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '\*\* PASS \*\*'; then
  exit 0
fi
exit 1

//--- verification/tb_rvv_backend_decode.sv
// testbench for the decode stage
// directed tests, reference uop model, compare tasks and watchdog
`timescale 1ns/1ps
`include "rvv_backend_config.svh"

module tb_rvv_backend_decode
  import rvv_backend_pkg::*;
();

  localparam int         CLK_PERIOD    = 4;
  localparam logic [6:0] OPC_ARITH     = 7'b1010111;
  // upper bound of uops over all tests, plus reset, stall and drain cycles
  localparam int         TOTAL_UOPS    = 1 + 8 + 7 + 20 * 4 + 16 * 4;
  localparam int         MARGIN_CYCLES = 200;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       cmd_valid;
  rvv_cmd_t   cmd;
  logic       cmd_ready;
  logic       uop_valid;
  uop_queue_t uop;
  logic       uop_ready;

  integer     seed = 31;
  uop_queue_t exp_q[$];
  string      test_name = "reset";
  int         error_count = 0;
  int         check_count = 0;
  int         test_count = 0;
  int         start_errors;

  rvv_backend_decode UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .uop_valid (uop_valid),
    .uop       (uop),
    .uop_ready (uop_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_uop(input uop_queue_t exp, input uop_queue_t act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s: expected %h actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // reference decode, one uop per register of the group
  task automatic add_expected(input rvv_cmd_t c);
    uop_queue_t u;
    int         n;
    logic [6:0] opc;
    n   = 1 << c.lmul;
    opc = c.insn.arith.opcode;
    for (int i = 0; i < n; i++) begin
      u = '0;
      if (opc == OPC_LOAD || opc == OPC_STORE) begin
        // memory ops have no vector sources, only the index offset
        u.uop_type = (opc == OPC_STORE) ? UOP_STORE : UOP_LOAD;
        u.funct    = {4'b0000, c.insn.mem.mop};
        u.vd       = c.insn.mem.vd + 5'(i);
        u.vs1      = 5'(i);
        u.vs2      = 5'(i);
      end else begin
        u.uop_type = UOP_ARITH;
        u.funct    = c.insn.arith.funct6;
        u.vd       = c.insn.arith.vd + 5'(i);
        u.vs1      = c.insn.arith.vs1 + 5'(i);
        u.vs2      = c.insn.arith.vs2 + 5'(i);
      end
      u.uop_index      = `UOP_INDEX_WIDTH'(i);
      u.last_uop_valid = (i == n - 1);
      exp_q.push_back(u);
    end
  endtask

  function automatic rvv_cmd_t make_arith(input logic [5:0] funct6, input logic [4:0] vs2,
                                          input logic [4:0] vs1, input logic [4:0] vd,
                                          input logic [1:0] lmul);
    rvv_cmd_t c;
    c                   = '0;
    c.insn.arith.funct6 = funct6;
    c.insn.arith.vm     = 1'b1;
    c.insn.arith.vs2    = vs2;
    c.insn.arith.vs1    = vs1;
    c.insn.arith.vd     = vd;
    c.insn.arith.opcode = OPC_ARITH;
    c.lmul              = lmul;
    return c;
  endfunction

  function automatic rvv_cmd_t make_mem(input logic store, input logic [1:0] mop,
                                        input logic [4:0] vd, input logic [4:0] rs1,
                                        input logic [1:0] lmul);
    rvv_cmd_t c;
    c                 = '0;
    c.insn.mem.mop    = mop;
    c.insn.mem.vm     = 1'b1;
    c.insn.mem.rs1    = rs1;
    c.insn.mem.vd     = vd;
    c.insn.mem.opcode = store ? OPC_STORE : OPC_LOAD;
    c.lmul            = lmul;
    return c;
  endfunction

  // random word, opcode forced to one of the three kinds
  function automatic rvv_cmd_t random_cmd(input logic [1:0] lmul);
    rvv_cmd_t c;
    int       kind;
    c.insn = $random(seed);
    kind   = {$random(seed)} % 3;
    case (kind)
      0:       c.insn.arith.opcode = OPC_ARITH;
      1:       c.insn.mem.opcode = OPC_LOAD;
      default: c.insn.mem.opcode = OPC_STORE;
    endcase
    c.lmul = lmul;
    return c;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_cmd(input rvv_cmd_t c);
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clk);
    while (!cmd_ready) begin
      @(negedge clk);
    end
    add_expected(c);
    next_cycle();
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    @(negedge clk);
    check_bit("uop_valid after drain", 1'b0, uop_valid);
    next_cycle();
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    start_errors = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == start_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, error_count - start_errors);
    end
  endtask

  task automatic test_reset_state();
    begin_test("reset_state");
    @(negedge clk);
    check_bit("uop_valid", 1'b0, uop_valid);
    check_bit("cmd_ready", 1'b1, cmd_ready);
    next_cycle();
    end_test();
  endtask

  task automatic test_single_arith();
    begin_test("single_arith");
    send_cmd(make_arith(6'h05, 5'd3, 5'd7, 5'd12, 2'd0));
    wait_drain();
    end_test();
  endtask

  task automatic test_lmul8();
    begin_test("lmul8");
    send_cmd(make_arith(6'h2a, 5'd16, 5'd24, 5'd8, 2'd3));
    wait_drain();
    end_test();
  endtask

  task automatic test_load_store();
    begin_test("load_store");
    send_cmd(make_mem(1'b0, 2'b00, 5'd4, 5'd10, 2'd1));
    send_cmd(make_mem(1'b1, 2'b10, 5'd20, 5'd11, 2'd0));
    send_cmd(make_mem(1'b1, 2'b01, 5'd28, 5'd2, 2'd2));
    wait_drain();
    end_test();
  endtask

  task automatic test_random_stream();
    begin_test("random_stream");
    for (int n = 0; n < 20; n++) begin
      send_cmd(random_cmd(2'({$random(seed)} % 3)));
    end
    wait_drain();
    end_test();
  endtask

  task automatic test_backpressure();
    int waited;
    begin_test("backpressure");
    uop_ready = 1'b0;
    fork
      begin
        for (int n = 0; n < 16; n++) begin
          send_cmd(random_cmd(2'd2));
        end
      end
    join_none
    waited = 0;
    @(negedge clk);
    while (cmd_ready && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (cmd_ready) begin
      error_count++;
      $display("ERROR %s: cmd_ready stayed high with the uop output stalled", test_name);
    end
    next_cycle();
    uop_ready = 1'b1;
    wait fork;
    wait_drain();
    end_test();
  endtask

  // transfer happens at the next rising edge
  always @(negedge clk) begin : monitor
    uop_queue_t exp_uop;
    if (rst_n && uop_valid && uop_ready) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("ERROR %s: a uop came out while none was expected", test_name);
      end else begin
        exp_uop = exp_q.pop_front();
        check_uop(exp_uop, uop);
      end
    end
  end

  initial begin : watchdog
    #((TOTAL_UOPS + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout in test %s with %0d uops still expected", test_name, exp_q.size());
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst_n     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    uop_ready = 1'b1;
    #1;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_single_arith();
    test_lmul8();
    test_load_store();
    test_random_stream();
    test_backpressure();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- hdl/rvv_backend_decode.sv
// decode stage top level
// command queue, two decode units, controller and uop queue
`timescale 1ns/1ps
`include "rvv_backend_config.svh"

module rvv_backend_decode
  import rvv_backend_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_valid,
  input  rvv_cmd_t   cmd,
  output logic       cmd_ready,
  output logic       uop_valid,
  output uop_queue_t uop,
  input  logic       uop_ready
);

  logic                         pkg0_valid;
  logic                         pkg1_valid;
  rvv_cmd_t                     pkg0_cmd;
  rvv_cmd_t                     pkg1_cmd;
  logic                         pop0;
  logic                         pop1;
  logic [`UOP_INDEX_WIDTH-1:0]  uop_index_remain;
  logic [`NUM_DE_UOP-1:0]       unit0_uop_valid;
  logic [`NUM_DE_UOP-1:0]       unit1_uop_valid;
  uop_queue_t [`NUM_DE_UOP-1:0] unit0_uops;
  uop_queue_t [`NUM_DE_UOP-1:0] unit1_uops;

  rvv_uq_push_if uq_if ();

  rvv_cmd_queue u_cmd_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .pkg0_valid (pkg0_valid),
    .pkg1_valid (pkg1_valid),
    .pkg0_cmd   (pkg0_cmd),
    .pkg1_cmd   (pkg1_cmd),
    .pop0       (pop0),
    .pop1       (pop1)
  );

  rvv_decode_unit #(.HAS_INDEX(1)) u_decode_unit0 (
    .pkg_valid (pkg0_valid),
    .pkg_cmd   (pkg0_cmd),
    .uop_index (uop_index_remain),
    .uop_valid (unit0_uop_valid),
    .uops      (unit0_uops)
  );

  // second unit always decodes from index 0
  rvv_decode_unit #(.HAS_INDEX(0)) u_decode_unit1 (
    .pkg_valid (pkg1_valid),
    .pkg_cmd   (pkg1_cmd),
    .uop_index ('0),
    .uop_valid (unit1_uop_valid),
    .uops      (unit1_uops)
  );

  rvv_backend_decode_ctrl u_decode_ctrl (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .pkg0_valid            (pkg0_valid),
    .pkg1_valid            (pkg1_valid),
    .unit0_uop_valid_de2uq (unit0_uop_valid),
    .unit1_uop_valid_de2uq (unit1_uop_valid),
    .unit0_uop_de2uq       (unit0_uops),
    .unit1_uop_de2uq       (unit1_uops),
    .uop_index_remain      (uop_index_remain),
    .pop0                  (pop0),
    .pop1                  (pop1),
    .uq                    (uq_if.ctrl)
  );

  rvv_uop_queue u_uop_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .uq        (uq_if.uq),
    .uop_valid (uop_valid),
    .uop       (uop),
    .uop_ready (uop_ready)
  );

endmodule

//--- hdl/rvv_uop_queue.sv
// uop FIFO
// four ordered push ports, one valid/ready pop port and fill-level flags
`timescale 1ns/1ps
`include "rvv_backend_config.svh"

module rvv_uop_queue
  import rvv_backend_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  rvv_uq_push_if.uq  uq,
  output logic       uop_valid,
  output uop_queue_t uop,
  input  logic       uop_ready
);

  localparam int AW = $clog2(`UQ_DEPTH);

  uop_queue_t                   mem [`UQ_DEPTH];
  logic [AW-1:0]                wr_ptr;
  logic [AW-1:0]                rd_ptr;
  logic [AW:0]                  count;
  logic [`NUM_DE_UOP-1:0]       push_vec;
  uop_queue_t [`NUM_DE_UOP-1:0] data_vec;
  logic [`NUM_DE_UOP_WIDTH-1:0] push_num;
  logic                         pop;

  assign push_vec = {uq.push3, uq.push2, uq.push1, uq.push0};
  assign data_vec = {uq.data3, uq.data2, uq.data1, uq.data0};

  always_comb begin
    push_num = '0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      push_num = push_num + `NUM_DE_UOP_WIDTH'(push_vec[k]);
    end
  end

  assign uop_valid = count != '0;
  assign uop       = mem[rd_ptr];
  assign pop       = uop_valid & uop_ready;

  // lane k lands k slots after the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (push_vec[k]) begin
        mem[wr_ptr + AW'(k)] <= data_vec[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(push_num);
      if (pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      count <= count + (AW+1)'(push_num) - (AW+1)'(pop);
    end
  end

  assign uq.fifo_full          = count == (AW+1)'(`UQ_DEPTH);
  assign uq.fifo_1left_to_full = count == (AW+1)'(`UQ_DEPTH - 1);
  assign uq.fifo_2left_to_full = count == (AW+1)'(`UQ_DEPTH - 2);
  assign uq.fifo_3left_to_full = count == (AW+1)'(`UQ_DEPTH - 3);

  // the controller's room check keeps writes inside the buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(count) + int'(push_num) - int'(pop)) <= `UQ_DEPTH);

endmodule

//--- hdl/rvv_backend_decode_ctrl.sv
// decode controller
// packs both units' uops into the four push lanes of the uop queue,
// pops finished commands and keeps the uop index of a split command
`timescale 1ns/1ps
`include "rvv_backend_config.svh"

module rvv_backend_decode_ctrl
  import rvv_backend_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pkg0_valid,
  input  logic                         pkg1_valid,
  input  logic [`NUM_DE_UOP-1:0]       unit0_uop_valid_de2uq,
  input  logic [`NUM_DE_UOP-1:0]       unit1_uop_valid_de2uq,
  input  uop_queue_t [`NUM_DE_UOP-1:0] unit0_uop_de2uq,
  input  uop_queue_t [`NUM_DE_UOP-1:0] unit1_uop_de2uq,
  output logic [`UOP_INDEX_WIDTH-1:0]  uop_index_remain,
  output logic                         pop0,
  output logic                         pop1,
  rvv_uq_push_if.ctrl                  uq
);

  logic [`NUM_DE_UOP_WIDTH-1:0] quantity;
  logic [`NUM_DE_UOP_WIDTH-1:0] free_lanes;
  logic                         unit0_last;
  logic                         unit1_last;
  logic                         fifo_ready;
  logic                         idx_clear;
  logic                         idx_en_unit0;
  logic                         idx_en_unit1;
  logic [`NUM_DE_UOP-1:0]       lane_valid;
  uop_queue_t [`NUM_DE_UOP-1:0] lane_data;

  // uops offered by unit 0
  always_comb begin
    quantity = '0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      quantity = quantity + `NUM_DE_UOP_WIDTH'(unit0_uop_valid_de2uq[k]);
    end
  end

  assign free_lanes = `NUM_DE_UOP_WIDTH'(`NUM_DE_UOP) - quantity;

  // fewer than four uops means unit 0 reached the end of its group
  assign unit0_last = (quantity < `NUM_DE_UOP_WIDTH'(`NUM_DE_UOP)) ? 1'b1
                    : unit0_uop_de2uq[`NUM_DE_UOP-1].last_uop_valid;

  // unit 1 finishes only if its last uop lands in a free lane
  always_comb begin
    unit1_last = 1'b0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (k < int'(free_lanes) && unit1_uop_valid_de2uq[k] &&
          unit1_uop_de2uq[k].last_uop_valid) begin
        unit1_last = 1'b1;
      end
    end
  end

  // unit 0 first, unit 1 fills from lane "quantity" upwards
  always_comb begin
    int j;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      j = k - int'(quantity);
      if (k < int'(quantity)) begin
        lane_valid[k] = unit0_uop_valid_de2uq[k];
        lane_data[k]  = unit0_uop_de2uq[k];
      end else begin
        lane_valid[k] = unit1_uop_valid_de2uq[j];
        lane_data[k]  = unit1_uop_de2uq[j];
      end
    end
  end

  // at least four free entries
  assign fifo_ready = !(uq.fifo_full | uq.fifo_1left_to_full |
                        uq.fifo_2left_to_full | uq.fifo_3left_to_full);

  assign pop0 = pkg0_valid & unit0_last & fifo_ready;
  assign pop1 = pkg1_valid & unit1_last & pop0;

  assign uq.push0 = lane_valid[0] & fifo_ready;
  assign uq.push1 = lane_valid[1] & fifo_ready;
  assign uq.push2 = lane_valid[2] & fifo_ready;
  assign uq.push3 = lane_valid[3] & fifo_ready;
  assign uq.data0 = lane_data[0];
  assign uq.data1 = lane_data[1];
  assign uq.data2 = lane_data[2];
  assign uq.data3 = lane_data[3];

  // next start index for unit 0
  assign idx_en_unit0 = fifo_ready & pkg0_valid & !unit0_last;
  assign idx_en_unit1 = pop0 & pkg1_valid & !unit1_last;
  assign idx_clear    = pop0 & !idx_en_unit1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_index_remain <= '0;
    end else if (idx_clear) begin
      uop_index_remain <= '0;
    end else if (idx_en_unit0) begin
      uop_index_remain <= uop_index_remain + `UOP_INDEX_WIDTH'(`NUM_DE_UOP);
    end else if (idx_en_unit1) begin
      // unit 1 command moves to the head and resumes after its lanes
      uop_index_remain <= `UOP_INDEX_WIDTH'(`NUM_DE_UOP) - `UOP_INDEX_WIDTH'(quantity);
    end
  end

  // both units hand over low-first thermometer valids
  a_thermometer: assert property (@(posedge clk) disable iff (!rst_n)
    ((unit0_uop_valid_de2uq & (unit0_uop_valid_de2uq + 1'b1)) == '0) &&
    ((unit1_uop_valid_de2uq & (unit1_uop_valid_de2uq + 1'b1)) == '0));

  // pushed lanes go out low first with no gap
  a_push_order: assert property (@(posedge clk) disable iff (!rst_n)
    ({uq.push3, uq.push2, uq.push1, uq.push0} &
     ({uq.push3, uq.push2, uq.push1, uq.push0} + 1'b1)) == '0);

endmodule

//--- hdl/rvv_decode_unit.sv
// decode unit
// splits one command into up to four consecutive uops of its register group
`timescale 1ns/1ps
`include "rvv_backend_config.svh"

module rvv_decode_unit
  import rvv_backend_pkg::*;
#(
  parameter int HAS_INDEX = 1
) (
  input  logic                         pkg_valid,
  input  rvv_cmd_t                     pkg_cmd,
  input  logic [`UOP_INDEX_WIDTH-1:0]  uop_index,
  output logic [`NUM_DE_UOP-1:0]       uop_valid,
  output uop_queue_t [`NUM_DE_UOP-1:0] uops
);

  // one extra bit so a group of 8 fits
  localparam int CW = `UOP_INDEX_WIDTH + 1;

  uop_type_e     uop_type;
  logic [5:0]    funct;
  logic [4:0]    vd_base;
  logic [4:0]    vs1_base;
  logic [4:0]    vs2_base;
  logic [CW-1:0] start_idx;
  logic [CW-1:0] total;
  logic [CW-1:0] remain;

  // pick the word view by opcode
  always_comb begin
    uop_type = UOP_ARITH;
    funct    = pkg_cmd.insn.arith.funct6;
    vd_base  = pkg_cmd.insn.arith.vd;
    vs1_base = pkg_cmd.insn.arith.vs1;
    vs2_base = pkg_cmd.insn.arith.vs2;
    if (pkg_cmd.insn.mem.opcode == OPC_LOAD || pkg_cmd.insn.mem.opcode == OPC_STORE) begin
      // memory access, vd is the data register, no vector sources
      uop_type = (pkg_cmd.insn.mem.opcode == OPC_STORE) ? UOP_STORE : UOP_LOAD;
      funct    = {4'b0000, pkg_cmd.insn.mem.mop};
      vd_base  = pkg_cmd.insn.mem.vd;
      vs1_base = '0;
      vs2_base = '0;
    end
  end

  // unit 1 always starts a fresh command
  assign start_idx = (HAS_INDEX != 0) ? {1'b0, uop_index} : '0;
  assign total     = CW'(1) << pkg_cmd.lmul;
  assign remain    = total - start_idx;

  for (genvar k = 0; k < `NUM_DE_UOP; k++) begin : g_lane
    logic [CW-1:0] idx;

    assign idx = start_idx + CW'(k);

    // thermometer valid, lanes below the remaining count
    assign uop_valid[k] = pkg_valid && (CW'(k) < remain);

    assign uops[k].uop_type       = uop_type;
    assign uops[k].funct          = funct;
    assign uops[k].vd             = vd_base + 5'(idx);
    assign uops[k].vs1            = vs1_base + 5'(idx);
    assign uops[k].vs2            = vs2_base + 5'(idx);
    assign uops[k].uop_index      = idx[`UOP_INDEX_WIDTH-1:0];
    assign uops[k].last_uop_valid = (idx + CW'(1)) == total;
  end

endmodule

//--- hdl/rvv_cmd_queue.sv
// command FIFO
// shows its two oldest entries, pops one or two per cycle
`timescale 1ns/1ps
`include "rvv_backend_config.svh"

module rvv_cmd_queue
  import rvv_backend_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  input  rvv_cmd_t cmd,
  output logic     cmd_ready,
  output logic     pkg0_valid,
  output logic     pkg1_valid,
  output rvv_cmd_t pkg0_cmd,
  output rvv_cmd_t pkg1_cmd,
  input  logic     pop0,
  input  logic     pop1
);

  localparam int AW = $clog2(`CQ_DEPTH);

  rvv_cmd_t      mem [`CQ_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic [1:0]    pop_num;

  assign push      = cmd_valid & cmd_ready;
  assign pop_num   = {1'b0, pop0} + {1'b0, pop1};
  assign cmd_ready = count != (AW+1)'(`CQ_DEPTH);

  // two oldest entries
  assign pkg0_valid = count != '0;
  assign pkg1_valid = count > (AW+1)'(1);
  assign pkg0_cmd   = mem[rd_ptr];
  assign pkg1_cmd   = mem[rd_ptr + AW'(1)];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      rd_ptr <= rd_ptr + AW'(pop_num);
      count  <= count + (AW+1)'(push) - (AW+1)'(pop_num);
    end
  end

  // the controller pops only shown entries and pop1 only together with pop0
  a_pop_legal: assert property (@(posedge clk) disable iff (!rst_n)
    (!pop0 || pkg0_valid) && (!pop1 || (pop0 && pkg1_valid)));

endmodule

//--- hdl/rvv_uq_push_if.sv
// push side of the uop queue
// four ordered push lanes and the fill-level flags
`timescale 1ns/1ps

interface rvv_uq_push_if
  import rvv_backend_pkg::*;
();

  // lanes are pushed low first, as a contiguous set
  logic       push0;
  logic       push1;
  logic       push2;
  logic       push3;
  uop_queue_t data0;
  uop_queue_t data1;
  uop_queue_t data2;
  uop_queue_t data3;

  // exactly 0, 1, 2 or 3 entries left
  logic       fifo_full;
  logic       fifo_1left_to_full;
  logic       fifo_2left_to_full;
  logic       fifo_3left_to_full;

  modport ctrl (
    output push0, push1, push2, push3,
    output data0, data1, data2, data3,
    input  fifo_full, fifo_1left_to_full, fifo_2left_to_full, fifo_3left_to_full
  );

  modport uq (
    input  push0, push1, push2, push3,
    input  data0, data1, data2, data3,
    output fifo_full, fifo_1left_to_full, fifo_2left_to_full, fifo_3left_to_full
  );

endinterface

//--- hdl/rvv_backend_pkg.sv
// decode stage types
// instruction word views, command and uop records
`include "rvv_backend_config.svh"

package rvv_backend_pkg;

  // major opcodes of vector memory accesses, anything else is arithmetic
  localparam logic [6:0] OPC_LOAD  = 7'b0000111;
  localparam logic [6:0] OPC_STORE = 7'b0100111;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } arith_fmt_t;

  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] lumop;
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] vd;
    logic [6:0] opcode;
  } mem_fmt_t;

  // same 32-bit word, two decodings
  typedef union packed {
    arith_fmt_t arith;
    mem_fmt_t   mem;
  } rvv_insn_u;

  typedef struct packed {
    rvv_insn_u  insn;
    logic [1:0] lmul;
  } rvv_cmd_t;

  typedef enum logic [1:0] {
    UOP_ARITH,
    UOP_LOAD,
    UOP_STORE
  } uop_type_e;

  // register fields already carry the uop_index offset
  typedef struct packed {
    uop_type_e                   uop_type;
    logic [5:0]                  funct;
    logic [4:0]                  vd;
    logic [4:0]                  vs1;
    logic [4:0]                  vs2;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    logic                        last_uop_valid;
  } uop_queue_t;

endpackage

//--- include/rvv_backend_config.svh
// sizes for the decode stage
// queue depths, uop lanes per decode unit and index widths
`ifndef RVV_BACKEND_CONFIG_SVH
`define RVV_BACKEND_CONFIG_SVH

// uop lanes per decode unit, also push ports of the uop queue
`define NUM_DE_UOP        4
// holds a count from 0 to NUM_DE_UOP
`define NUM_DE_UOP_WIDTH  3

// index of a uop inside its register group, up to 8 uops
`define UOP_INDEX_WIDTH   3

// queue depths, powers of two
`define CQ_DEPTH          8
`define UQ_DEPTH          16

`endif
